//--- ghash_pkg.sv
package ghash_pkg;

   // Field width, default for the top level only
   localparam int NB_DATA = 128;

   // Table index width, the table method works a byte at a time
   localparam int NB_BYTE = 8;

   // Entries of the M0 table, indexed by the seven low bits of a byte
   localparam int NB_TABLE = 2 ** (NB_BYTE - 1);

   // Reduction byte for x^128 = 1 + x + x^2 + x^7, reflected GCM order
   localparam logic [NB_BYTE-1:0] R_BYTE = 8'he1;

   // One field element, bit 127 holds the x^0 coefficient
   typedef logic [NB_DATA-1:0] gf128_t;

   // Products of H with every seven-bit pattern
   typedef gf128_t [NB_TABLE-1:0] m0_table_t;

   // Block from the host with its end-of-message marker
   typedef struct packed {
      gf128_t data;
      logic   last;
   } ghash_block_t;

   // Reduction pattern for one byte shifted out of the word
   // Index bit m stands for x^(128+m) after the byte shift
   // R folded m times still fits in the top 16 bits
   function automatic logic [2*NB_BYTE-1:0] r_table_entry
   (
      input logic [NB_BYTE-1:0] index
   );
      logic [2*NB_BYTE-1:0] pattern;
      logic [2*NB_BYTE-1:0] result;
      pattern = {R_BYTE, {NB_BYTE{1'b0}}};
      result  = '0;
      for (int m = 0; m < NB_BYTE; m++)
      begin
         // R times x^m, a right shift in reflected order
         if (index[m])
         begin
            result = result ^ (pattern >> m);
         end
      end
      return result;
   endfunction

endpackage

//--- m0_table_generator.sv
`timescale 1ns/1ns

module m0_table_generator
#(
   parameter int NB_DATA = 128
)
(
   input  logic                 i_clock,
   input  logic                 i_reset,
   input  logic                 i_valid,
   input  ghash_pkg::gf128_t    i_H,
   output ghash_pkg::gf128_t    o_H,
   output ghash_pkg::m0_table_t o_value
);

   import ghash_pkg::*;

   // H times x^j, j = 0 to 7
   gf128_t    h_pow [NB_BYTE];

   // Table built from the incoming key
   m0_table_t table_next;

   // One step of multiplication by x in GCM bit order
   function automatic gf128_t mul_x
   (
      input gf128_t value
   );
      gf128_t shifted;
      shifted = value >> 1;
      // x^127 falls off the bottom, fold it back with R
      if (value[0])
      begin
         shifted[NB_DATA-1 -: NB_BYTE] = shifted[NB_DATA-1 -: NB_BYTE] ^ R_BYTE;
      end
      return shifted;
   endfunction

   // Chain of shifted and reduced copies of H
   always_comb
   begin
      h_pow[0] = i_H;
      for (int j = 1; j < NB_BYTE; j++)
      begin
         h_pow[j] = mul_x(h_pow[j-1]);
      end
   end

   // Byte bit k is the x^(7-k) coefficient
   // Bit 7 (x^0) is left to the multiplier, which adds H directly
   always_comb
   begin
      for (int idx = 0; idx < NB_TABLE; idx++)
      begin
         table_next[idx] = '0;
         for (int k = 0; k < NB_BYTE - 1; k++)
         begin
            if (idx[k])
            begin
               table_next[idx] = table_next[idx] ^ h_pow[NB_BYTE-1-k];
            end
         end
      end
   end

   // Key and table captured on the load strobe
   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         o_H     <= '0;
         o_value <= '0;
      end
      else if (i_valid)
      begin
         o_H     <= i_H;
         o_value <= table_next;
      end
   end

endmodule

//--- gf_multiplier_gcm_spec.sv
`timescale 1ns/1ns

module gf_multiplier_gcm_spec
#(
   parameter int NB_DATA = 128
)
(
   input  logic                 i_clock,
   input  logic                 i_reset,
   input  logic                 i_valid,
   input  ghash_pkg::gf128_t    i_data_x,
   input  ghash_pkg::gf128_t    i_data_x_prev,
   input  ghash_pkg::gf128_t    i_H,
   input  ghash_pkg::m0_table_t i_m0_table,
   output ghash_pkg::gf128_t    o_value
);

   import ghash_pkg::*;

   // Bytes per field element
   localparam int NB_WORD = NB_DATA / NB_BYTE;

   // Block folded into the running value
   gf128_t x_xor;

   // H times byte i of x_xor
   gf128_t m0_value [NB_WORD];

   // Partial result entering the step for byte i
   gf128_t z_acc [NB_WORD];

   // Reflect a byte so bit m selects R times x^m
   function automatic logic [NB_BYTE-1:0] bit_reverse
   (
      input logic [NB_BYTE-1:0] value
   );
      logic [NB_BYTE-1:0] result;
      for (int b = 0; b < NB_BYTE; b++)
      begin
         result[b] = value[NB_BYTE-1-b];
      end
      return result;
   endfunction

   assign x_xor = i_data_x ^ i_data_x_prev;

   // Table lookup for every byte
   // Byte 0 is the top byte of the word, the first byte on the wire
   for (genvar ii = 0; ii < NB_WORD; ii++)
   begin : g_lookup
      logic [NB_BYTE-1:0] x_byte;
      gf128_t             h_term;

      assign x_byte = x_xor[NB_DATA-(ii+1)*NB_BYTE +: NB_BYTE];

      // Top bit of the byte is x^0, so it adds plain H
      assign h_term = x_byte[NB_BYTE-1] ? i_H : '0;

      assign m0_value[ii] = i_m0_table[x_byte[NB_BYTE-2:0]] ^ h_term;
   end

   // Horner walk starts empty at the last byte
   assign z_acc[NB_WORD-1] = '0;

   // Bytes 15 down to 1, each followed by a multiply by x^8
   for (genvar ii = NB_WORD - 1; ii > 0; ii = ii - 1)
   begin : g_stage
      gf128_t             z_mix;
      logic [NB_BYTE-1:0] r_index;
      gf128_t             r_fold;

      // Z = Z xor M0[byte]
      assign z_mix = z_acc[ii] ^ m0_value[ii];

      // Low byte (x^120..x^127) is lost by the shift
      assign r_index = bit_reverse(z_mix[NB_BYTE-1:0]);

      // Its reduction goes back in at the top two bytes
      assign r_fold = {r_table_entry(r_index), {(NB_DATA-2*NB_BYTE){1'b0}}};

      assign z_acc[ii-1] = (z_mix >> NB_BYTE) ^ r_fold;
   end

   // Byte 0 added without a shift, product held until the next block
   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         o_value <= '0;
      end
      else if (i_valid)
      begin
         o_value <= z_acc[0] ^ m0_value[0];
      end
   end

endmodule

//--- ghash_controller.sv
`timescale 1ns/1ns

module ghash_controller
#(
   parameter int NB_DATA = 128
)
(
   input  logic                    i_clock,
   input  logic                    i_reset,
   input  logic                    i_key_load,
   input  logic                    i_block_valid,
   input  ghash_pkg::ghash_block_t i_block,
   input  ghash_pkg::gf128_t       i_y,
   output logic                    o_table_load,
   output logic                    o_mul_valid,
   output ghash_pkg::gf128_t       o_data_x,
   output ghash_pkg::gf128_t       o_data_x_prev,
   output logic                    o_key_ready,
   output ghash_pkg::gf128_t       o_tag,
   output logic                    o_tag_valid
);

   // Block taken this cycle
   logic block_accept;

   // Next accepted block opens a new message
   logic msg_start;

   // Blocks before the first key are dropped
   assign block_accept = i_block_valid & o_key_ready;

   // Key pulse goes straight to the table registers
   assign o_table_load = i_key_load;

   assign o_mul_valid = block_accept;
   assign o_data_x    = i_block.data;

   // First block of a message sees Y = 0, not the old tag
   assign o_data_x_prev = msg_start ? {NB_DATA{1'b0}} : i_y;

   // Running Y doubles as the tag
   assign o_tag = i_y;

   // Key ready stays up until reset
   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         o_key_ready <= 1'b0;
      end
      else if (i_key_load)
      begin
         o_key_ready <= 1'b1;
      end
   end

   // Set again by each last block
   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         msg_start <= 1'b1;
      end
      else if (block_accept)
      begin
         msg_start <= i_block.last;
      end
   end

   // Pulse lines up with the final product in the multiplier register
   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         o_tag_valid <= 1'b0;
      end
      else
      begin
         o_tag_valid <= block_accept & i_block.last;
      end
   end

endmodule

//--- ghash_core.sv
`timescale 1ns/1ns

module ghash_core
#(
   parameter int NB_DATA = ghash_pkg::NB_DATA
)
(
   input  logic                    i_clock,
   input  logic                    i_reset,
   input  logic                    i_key_load,
   input  ghash_pkg::gf128_t       i_key,
   input  logic                    i_block_valid,
   input  ghash_pkg::ghash_block_t i_block,
   output logic                    o_key_ready,
   output ghash_pkg::gf128_t       o_tag,
   output logic                    o_tag_valid
);

   import ghash_pkg::*;

   // Controller to table and multiplier
   logic      table_load;
   logic      mul_valid;
   gf128_t    data_x;
   gf128_t    data_x_prev;

   // Registered key material
   gf128_t    h_reg;
   m0_table_t m0_table;

   // Running Y back to the controller
   gf128_t    y_value;

   ghash_controller
   #(
      .NB_DATA       (NB_DATA)
   )
   u_ghash_controller
   (
      .i_clock       (i_clock),
      .i_reset       (i_reset),
      .i_key_load    (i_key_load),
      .i_block_valid (i_block_valid),
      .i_block       (i_block),
      .i_y           (y_value),
      .o_table_load  (table_load),
      .o_mul_valid   (mul_valid),
      .o_data_x      (data_x),
      .o_data_x_prev (data_x_prev),
      .o_key_ready   (o_key_ready),
      .o_tag         (o_tag),
      .o_tag_valid   (o_tag_valid)
   );

   m0_table_generator
   #(
      .NB_DATA (NB_DATA)
   )
   u_m0_table_generator
   (
      .i_clock (i_clock),
      .i_reset (i_reset),
      .i_valid (table_load),
      .i_H     (i_key),
      .o_H     (h_reg),
      .o_value (m0_table)
   );

   gf_multiplier_gcm_spec
   #(
      .NB_DATA       (NB_DATA)
   )
   u_gf_multiplier_gcm_spec
   (
      .i_clock       (i_clock),
      .i_reset       (i_reset),
      .i_valid       (mul_valid),
      .i_data_x      (data_x),
      .i_data_x_prev (data_x_prev),
      .i_H           (h_reg),
      .i_m0_table    (m0_table),
      .o_value       (y_value)
   );

endmodule

//--- tb_ghash_core.sv
`timescale 1ns/1ns

module tb_ghash_core;

   import ghash_pkg::*;

   // Half period in ns and lengths in cycles
   localparam int CLK_HALF     = 10;
   localparam int RESET_CYCLES = 2;
   localparam int KEY_CYCLES   = 2;

   // Longest wait for a tag pulse in cycles
   localparam int TAG_WAIT = 8;

   localparam logic [31:0] RAND_SEED = 32'h9340_85a3;

   // One line of the vector file
   typedef struct packed {
      logic [7:0]  kind;
      logic [31:0] arg_a;
      logic [31:0] arg_b;
      gf128_t      data;
   } record_t;

   logic         i_clock;
   logic         i_reset;
   logic         i_key_load;
   gf128_t       i_key;
   logic         i_block_valid;
   ghash_block_t i_block;
   logic         o_key_ready;
   gf128_t       o_tag;
   logic         o_tag_valid;

   record_t records [$];

   // Software copy of the hash state
   gf128_t model_h;
   gf128_t model_y;
   gf128_t model_tag;

   // Set once the first key has been given
   bit     key_loaded;

   int  error_count;
   int  check_count;
   int  cycle_count;
   int  cycle_budget;
   int  cycle_limit;
   bit  file_ok;

   ghash_core
   #(
      .NB_DATA       (NB_DATA)
   )
   i_ghash_core
   (
      .i_clock       (i_clock),
      .i_reset       (i_reset),
      .i_key_load    (i_key_load),
      .i_key         (i_key),
      .i_block_valid (i_block_valid),
      .i_block       (i_block),
      .o_key_ready   (o_key_ready),
      .o_tag         (o_tag),
      .o_tag_valid   (o_tag_valid)
   );

   initial
   begin
      i_clock = 1'b0;
      forever #CLK_HALF i_clock = ~i_clock;
   end

   // Watchdog on the whole run
   always @(posedge i_clock)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit)
      begin
         $display("Timeout after %0d cycles, the run did not finish", cycle_count);
         $display("Something failed");
         $finish;
      end
   end

   // Textbook GCM multiply with one bit of x per step
   task automatic gcm_multiply(input gf128_t x, input gf128_t y, output gf128_t z);
      gf128_t v;
      z = '0;
      v = y;
      for (int i = 0; i < NB_DATA; i++)
      begin
         if (x[NB_DATA-1-i])
         begin
            z = z ^ v;
         end
         // Bit 0 leaving means x^128 and brings in R
         if (v[0])
         begin
            v = (v >> 1) ^ {8'he1, {(NB_DATA-8){1'b0}}};
         end
         else
         begin
            v = v >> 1;
         end
      end
   endtask

   function automatic int record_cycles(input record_t rec);
      case (rec.kind)
         "K":     return KEY_CYCLES;
         "B":     return rec.arg_a + 1;
         "T":     return 2;
         "N":     return rec.arg_a;
         // Key, then gap and block for each block, then tag
         "R":     return rec.arg_a * (KEY_CYCLES + 2 * rec.arg_b + 2);
         default: return 0;
      endcase
   endfunction

   task automatic read_testdata(output bit ok);
      int      fd;
      int      n;
      int      a;
      int      b;
      string   line;
      string   kind_str;
      gf128_t  d;
      record_t rec;
      ok = 1'b0;
      fd = $fopen("ghash_testdata.txt", "r");
      if (fd != 0)
      begin
         ok = 1'b1;
         while ($fgets(line, fd) != 0)
         begin
            a = 0;
            b = 0;
            d = '0;
            // Comment and blank lines give no match
            case (line.getc(0))
               "K", "T": n = $sscanf(line, "%s %h", kind_str, d);
               "B":      n = $sscanf(line, "%s %d %d %h", kind_str, a, b, d);
               "N":      n = $sscanf(line, "%s %d", kind_str, a);
               "R":      n = $sscanf(line, "%s %d %d", kind_str, a, b);
               default:  n = 0;
            endcase
            if (n > 0)
            begin
               rec = '{kind: line.getc(0), arg_a: a, arg_b: b, data: d};
               records.push_back(rec);
               cycle_budget = cycle_budget + record_cycles(rec);
            end
         end
         $fclose(fd);
      end
   endtask

   function automatic gf128_t random_word();
      return {$urandom(), $urandom(), $urandom(), $urandom()};
   endfunction

   task automatic load_key(input gf128_t key);
      i_key_load = 1'b1;
      i_key      = key;
      @(negedge i_clock);
      i_key_load = 1'b0;
      model_h    = key;
      model_y    = '0;
      key_loaded = 1'b1;
      check_count++;
      if (o_key_ready !== 1'b1)
      begin
         error_count++;
         $display("ERR o_key_ready got %h expected %h", o_key_ready, 1'b1);
      end
   endtask

   // Idle gap in cycles and then one block for one cycle
   task automatic send_block(input int gap, input bit last, input gf128_t data);
      gf128_t prod;
      repeat (gap) @(negedge i_clock);
      // Blocks before the first key are not part of any message
      if (key_loaded)
      begin
         gcm_multiply(model_y ^ data, model_h, prod);
         model_y = prod;
         if (last)
         begin
            model_tag = model_y;
            model_y   = '0;
         end
      end
      i_block_valid = 1'b1;
      i_block       = '{data: data, last: last};
      @(negedge i_clock);
      i_block_valid = 1'b0;
   endtask

   task automatic expect_tag(input bit use_file, input gf128_t file_tag);
      int waited;
      waited = 0;
      while (!o_tag_valid && waited < TAG_WAIT)
      begin
         @(negedge i_clock);
         waited++;
      end
      check_count++;
      if (!o_tag_valid)
      begin
         error_count++;
         $display("No tag pulse within %0d cycles after the last block", TAG_WAIT);
      end
      else
      begin
         if (waited != 0)
         begin
            error_count++;
            $display("Tag pulse came %0d cycles late", waited);
         end
         if (use_file && o_tag !== file_tag)
         begin
            error_count++;
            $display("ERR o_tag got %h expected %h (file)", o_tag, file_tag);
         end
         if (o_tag !== model_tag)
         begin
            error_count++;
            $display("ERR o_tag got %h expected %h (model)", o_tag, model_tag);
         end
         @(negedge i_clock);
         // Single-cycle pulse
         if (o_tag_valid !== 1'b0)
         begin
            error_count++;
            $display("ERR o_tag_valid got %h expected %h", o_tag_valid, 1'b0);
         end
      end
   endtask

   task automatic expect_no_tag(input int cycles);
      for (int c = 0; c < cycles; c++)
      begin
         check_count++;
         if (o_tag_valid !== 1'b0)
         begin
            error_count++;
            $display("ERR o_tag_valid got %h expected %h", o_tag_valid, 1'b0);
         end
         @(negedge i_clock);
      end
   endtask

   // Fresh random key and one to max_blocks blocks per message
   task automatic run_random(input int msgs, input int max_blocks);
      int nblk;
      for (int m = 0; m < msgs; m++)
      begin
         load_key(random_word());
         nblk = 1 + ($urandom() % max_blocks);
         for (int b = 0; b < nblk; b++)
         begin
            send_block($urandom() % 2, b == nblk - 1, random_word());
         end
         expect_tag(1'b0, '0);
      end
   endtask

   task automatic run_record(input record_t rec);
      case (rec.kind)
         "K":     load_key(rec.data);
         "B":     send_block(rec.arg_a, rec.arg_b[0], rec.data);
         "T":     expect_tag(1'b1, rec.data);
         "N":     expect_no_tag(rec.arg_a);
         "R":     run_random(rec.arg_a, rec.arg_b);
         default: ;
      endcase
   endtask

   initial
   begin
      i_reset       = 1'b1;
      i_key_load    = 1'b0;
      i_key         = '0;
      i_block_valid = 1'b0;
      i_block       = '0;
      model_h       = '0;
      model_y       = '0;
      model_tag     = '0;
      key_loaded    = 1'b0;
      error_count   = 0;
      check_count   = 0;
      cycle_count   = 0;
      cycle_budget  = 0;
      cycle_limit   = 1000;
      void'($urandom(RAND_SEED));
      read_testdata(file_ok);
      cycle_limit = 4 * cycle_budget + RESET_CYCLES + KEY_CYCLES;
      if (!file_ok)
      begin
         $display("Could not open ghash_testdata.txt for reading");
         $display("Something failed");
         $finish;
      end
      else
      begin
         repeat (RESET_CYCLES) @(negedge i_clock);
         i_reset = 1'b0;
         check_count++;
         if (o_key_ready !== 1'b0)
         begin
            error_count++;
            $display("ERR o_key_ready got %h expected %h", o_key_ready, 1'b0);
         end
         check_count++;
         if (o_tag_valid !== 1'b0)
         begin
            error_count++;
            $display("ERR o_tag_valid got %h expected %h", o_tag_valid, 1'b0);
         end
         foreach (records[r])
         begin
            run_record(records[r]);
         end
         $display("Checks: %0d  errors: %0d", check_count, error_count);
         if (error_count == 0)
         begin
            $display("Everything OK");
         end
         else
         begin
            $display("Something failed");
         end
         $finish;
      end
   end

endmodule

//--- ghash_testdata.txt
# K key | B gap last block | T expected tag | N cycles with no tag pulse
# R messages max_blocks (random keys and blocks, checked against the model)
B 0 1 0123456789abcdef0123456789abcdef
N 3
K 66e94bd4ef8a2c3b884cfa59ca342b2e
B 0 1 00000000000000000000000000000000
T 00000000000000000000000000000000
B 0 0 0388dace60b6a392f328c2b971b2fe78
B 0 1 00000000000000000000000000000080
T f38cbb1ad69223dcc3457ae5b6b0f885
K b83b533708bf535d0aa6e52980d53b78
B 0 0 42831ec2217774244b7221b784d0d49c
B 0 0 e3aa212f2c02a4e035c17e2329aca12e
B 0 0 21d514b25466931c7d8f6a5aac84aa05
B 0 0 1ba30b396a0aac973d58e091473f5985
B 0 1 00000000000000000000000000000200
T 7f1b32b81b820d02614f8895ac1d4eac
B 2 0 42831ec2217774244b7221b784d0d49c
B 1 0 e3aa212f2c02a4e035c17e2329aca12e
B 3 0 21d514b25466931c7d8f6a5aac84aa05
B 1 0 1ba30b396a0aac973d58e091473f5985
B 2 1 00000000000000000000000000000200
T 7f1b32b81b820d02614f8895ac1d4eac
R 24 8

//--- src.f
ghash_pkg.sv
m0_table_generator.sv
gf_multiplier_gcm_spec.sv
ghash_controller.sv
ghash_core.sv
tb_ghash_core.sv
